/* Makefile */
# Verilator build and run for the LSU testbench

LOG := sim.log

.PHONY: all build lint clean

all: build
	./obj_dir/Vlsu_tb | tee $(LOG)
	@grep -qx "TEST OK" $(LOG) || (echo "Simulation failed, see $(LOG)" && exit 1)
	@echo "Simulation passed"

build:
	verilator --binary --timing --assert --timescale 1ns/1ns \
		--top-module lsu_tb -f lsu_top.f -Mdir obj_dir

lint:
	verilator --lint-only --timing --timescale 1ns/1ns \
		--top-module lsu_top -f lsu_top.f

clean:
	rm -rf obj_dir $(LOG)

/* lsu_top.f */
source/lsu_pkg.sv
source/lsu_request.sv
source/lsu_tag_fifo.sv
source/lsu_response.sv
source/lsu_top.sv
verification/lsu_tb.sv

/* source/lsu_pkg.sv */
// LSU package with data widths, access descriptor, load/store encodings and fault codes
package lsu_pkg;

    //--------------------------------------------------
    // Data types
    //--------------------------------------------------
    typedef logic [31:0] word_t;
    typedef logic [31:0] inst_t;
    typedef logic [3:0]  strobe_t;
    typedef logic [5:0]  exc_t;
    typedef logic [6:0]  opc_t;
    typedef logic [2:0]  funct3_t;

    // Access descriptor {addr[31:0], signed, half, byte, load}
    typedef logic [35:0] tag_t;

    //--------------------------------------------------
    // Instruction encodings
    //--------------------------------------------------
    localparam opc_t OPC_LOAD  = 7'b0000011;
    localparam opc_t OPC_STORE = 7'b0100011;

    // Size in bits [1:0], unsigned load in bit 2
    localparam funct3_t F3_B  = 3'b000;
    localparam funct3_t F3_H  = 3'b001;
    localparam funct3_t F3_W  = 3'b010;
    localparam funct3_t F3_BU = 3'b100;
    localparam funct3_t F3_HU = 3'b101;

    //--------------------------------------------------
    // Writeback exception codes
    //--------------------------------------------------
    // RISC-V cause with bit 4 set as valid marker
    localparam exc_t EXC_MISALIGNED_LOAD  = 6'h14;
    localparam exc_t EXC_FAULT_LOAD       = 6'h15;
    localparam exc_t EXC_MISALIGNED_STORE = 6'h16;
    localparam exc_t EXC_FAULT_STORE      = 6'h17;

    //--------------------------------------------------
    // Tag FIFO sizing
    //--------------------------------------------------
    // One access in flight plus one being issued
    localparam int TAG_DEPTH = 2;
    localparam int TAG_PTR_W = $clog2(TAG_DEPTH);

    typedef logic [TAG_PTR_W-1:0] tag_ptr_t;
    typedef logic [TAG_PTR_W:0]   tag_cnt_t;

endpackage

/* source/lsu_request.sv */
// LSU request stage that decodes loads and stores, forms addresses and issues memory requests
`timescale 1ns/1ns

module lsu_request
    import lsu_pkg::*;
(
    input  logic    clk_i,
    input  logic    rst_i,
    input  logic    opcode_valid_i,
    input  inst_t   opcode_opcode_i,
    input  word_t   opcode_ra_operand_i,
    input  word_t   opcode_rb_operand_i,
    input  logic    mem_accept_i,
    input  logic    mem_ack_i,
    input  logic    mem_error_i,
    output word_t   mem_addr_o,
    output word_t   mem_data_wr_o,
    output logic    mem_rd_o,
    output strobe_t mem_wr_o,
    output logic    stall_o,
    output logic    tag_push_o,
    output tag_t    tag_data_o,
    output logic    dummy_ack_o
);

    opc_t    opc;
    funct3_t funct3;
    logic    is_load;
    logic    is_store;
    logic    size_b;
    logic    size_h;
    logic    size_w;
    word_t   imm_i;
    word_t   imm_s;
    word_t   addr_r;
    logic    misaligned_r;
    word_t   data_r;
    strobe_t strobe_r;

    logic    req_rd_q;
    strobe_t req_wr_q;
    logic    req_unaligned_q;
    word_t   req_addr_q;
    word_t   req_data_q;
    logic    req_load_q;
    logic    req_byte_q;
    logic    req_half_q;
    logic    req_signed_q;

    logic    outstanding_q;
    logic    dummy_ack_q;
    logic    req_pending;
    logic    req_busy;
    logic    issue;
    logic    delay;

    //--------------------------------------------------
    // Decode and address generation
    //--------------------------------------------------
    assign opc    = opcode_opcode_i[6:0];
    assign funct3 = opcode_opcode_i[14:12];

    assign is_load  = opcode_valid_i && (opc == OPC_LOAD) &&
                      (funct3 == F3_B || funct3 == F3_H || funct3 == F3_W ||
                       funct3 == F3_BU || funct3 == F3_HU);
    assign is_store = opcode_valid_i && (opc == OPC_STORE) &&
                      (funct3 == F3_B || funct3 == F3_H || funct3 == F3_W);

    // Access size shared by loads and stores
    assign size_b = (funct3[1:0] == F3_B[1:0]);
    assign size_h = (funct3[1:0] == F3_H[1:0]);
    assign size_w = (funct3[1:0] == F3_W[1:0]);

    assign imm_i = {{20{opcode_opcode_i[31]}}, opcode_opcode_i[31:20]};
    assign imm_s = {{20{opcode_opcode_i[31]}}, opcode_opcode_i[31:25],
                    opcode_opcode_i[11:7]};

    assign addr_r       = opcode_ra_operand_i + (is_store ? imm_s : imm_i);
    assign misaligned_r = (is_load || is_store) &&
                          ((size_w && addr_r[1:0] != 2'b00) || (size_h && addr_r[0]));

    // Store data moved onto its byte lanes
    always_comb
    begin
        data_r   = '0;
        strobe_r = '0;
        if (is_store && !misaligned_r)
        begin
            if (size_b)
            begin
                data_r   = word_t'(opcode_rb_operand_i[7:0]) << {addr_r[1:0], 3'b000};
                strobe_r = strobe_t'(4'b0001) << addr_r[1:0];
            end
            else if (size_h)
            begin
                data_r   = word_t'(opcode_rb_operand_i[15:0]) << {addr_r[1], 4'b0000};
                strobe_r = addr_r[1] ? 4'b1100 : 4'b0011;
            end
            else
            begin
                data_r   = opcode_rb_operand_i;
                strobe_r = 4'b1111;
            end
        end
    end

    //--------------------------------------------------
    // Outstanding access tracking
    //--------------------------------------------------
    assign req_pending = mem_rd_o || (mem_wr_o != '0);
    assign issue       = req_pending && mem_accept_i;

    // Earlier access in flight and not acknowledged this cycle
    assign delay = outstanding_q && !mem_ack_i;

    always_ff @(posedge clk_i or posedge rst_i)
    begin
        if (rst_i)
            outstanding_q <= 1'b0;
        else if (issue)
            outstanding_q <= 1'b1;
        else if (mem_ack_i)
            outstanding_q <= 1'b0;
    end

    //--------------------------------------------------
    // Request register
    //--------------------------------------------------
    assign req_busy = req_rd_q || (req_wr_q != '0) || req_unaligned_q;

    always_ff @(posedge clk_i or posedge rst_i)
    begin
        if (rst_i)
        begin
            req_rd_q        <= 1'b0;
            req_wr_q        <= '0;
            req_unaligned_q <= 1'b0;
        end
        else if (!stall_o)
        begin
            req_rd_q        <= is_load && !misaligned_r;
            req_wr_q        <= strobe_r;
            req_unaligned_q <= misaligned_r;
        end
        else if (req_unaligned_q && !delay)
        begin
            // Misaligned entry retires once nothing older is in flight
            req_unaligned_q <= 1'b0;
        end
    end

    always_ff @(posedge clk_i)
    begin
        if (!stall_o && opcode_valid_i)
        begin
            req_addr_q   <= addr_r;
            req_data_q   <= data_r;
            req_load_q   <= is_load;
            req_byte_q   <= size_b;
            req_half_q   <= size_h;
            req_signed_q <= !funct3[2];
        end
    end

    always_ff @(posedge clk_i or posedge rst_i)
    begin
        if (rst_i)
            dummy_ack_q <= 1'b0;
        else
            dummy_ack_q <= req_unaligned_q && !delay;
    end

    //--------------------------------------------------
    // Outputs
    //--------------------------------------------------
    assign mem_addr_o    = {req_addr_q[31:2], 2'b00};
    assign mem_data_wr_o = req_data_q;
    assign mem_rd_o      = req_rd_q && !delay;
    assign mem_wr_o      = delay ? '0 : req_wr_q;

    assign stall_o = (req_pending && !mem_accept_i) || (delay && req_busy) || req_unaligned_q;

    assign tag_push_o  = issue || (req_unaligned_q && !delay);
    assign tag_data_o  = {req_addr_q, req_signed_q, req_half_q, req_byte_q, req_load_q};
    assign dummy_ack_o = dummy_ack_q;

    // Back-pressured request holds until accepted
    assert property (@(posedge clk_i) disable iff (rst_i)
        (req_pending && !mem_accept_i) |=>
            ($stable(mem_addr_o) && $stable(mem_data_wr_o) &&
             $stable(mem_rd_o) && $stable(mem_wr_o)))
        else $error("lsu_request: request changed while waiting for accept");

    assert property (@(posedge clk_i) disable iff (rst_i)
        !(mem_rd_o && (mem_wr_o != '0)))
        else $error("lsu_request: read and write requested together");

    // Acks and bus errors only for an access in flight
    assert property (@(posedge clk_i) disable iff (rst_i)
        (mem_ack_i || mem_error_i) |-> outstanding_q)
        else $error("lsu_request: response without an outstanding access");

endmodule

/* source/lsu_response.sv */
// LSU response stage that aligns load data, classifies faults and drives the writeback
`timescale 1ns/1ns

module lsu_response
    import lsu_pkg::*;
(
    input  logic  clk_i,
    input  logic  rst_i,
    input  logic  mem_ack_i,
    input  logic  mem_error_i,
    input  word_t mem_data_rd_i,
    input  logic  dummy_ack_i,
    input  tag_t  tag_i,
    output logic  tag_pop_o,
    output logic  writeback_valid_o,
    output word_t writeback_value_o,
    output exc_t  writeback_exception_o
);

    word_t tag_addr;
    logic  tag_signed;
    logic  tag_half;
    logic  tag_byte;
    logic  tag_load;
    logic  fault_bus;
    logic  fault_align;
    logic  complete;
    word_t load_shift;
    word_t load_data;

    assign {tag_addr, tag_signed, tag_half, tag_byte, tag_load} = tag_i;

    assign fault_bus   = mem_ack_i && mem_error_i;
    assign fault_align = dummy_ack_i;
    assign complete    = mem_ack_i || dummy_ack_i;

    //--------------------------------------------------
    // Load extraction
    //--------------------------------------------------
    // Addressed lane moved down to bit 0
    assign load_shift = mem_data_rd_i >> {tag_addr[1:0], 3'b000};

    always_comb
    begin
        if (tag_byte)
            load_data = {{24{tag_signed & load_shift[7]}}, load_shift[7:0]};
        else if (tag_half)
            load_data = {{16{tag_signed & load_shift[15]}}, load_shift[15:0]};
        else
            load_data = mem_data_rd_i;
    end

    //--------------------------------------------------
    // Writeback
    //--------------------------------------------------
    always_comb
    begin
        writeback_value_o     = '0;
        writeback_exception_o = '0;
        if (fault_align || fault_bus)
        begin
            // Faulting address goes out as the result
            writeback_value_o = tag_addr;
            if (fault_align)
                writeback_exception_o = tag_load ? EXC_MISALIGNED_LOAD : EXC_MISALIGNED_STORE;
            else
                writeback_exception_o = tag_load ? EXC_FAULT_LOAD : EXC_FAULT_STORE;
        end
        else if (mem_ack_i && tag_load)
            writeback_value_o = load_data;
    end

    assign writeback_valid_o = complete;
    assign tag_pop_o         = complete;

    // Misaligned completions never overlap a memory ack
    assert property (@(posedge clk_i) disable iff (rst_i)
        !(mem_ack_i && dummy_ack_i))
        else $error("lsu_response: memory ack and dummy ack together");

endmodule

/* source/lsu_tag_fifo.sv */
// Tag FIFO that keeps access descriptors in issue order until they complete
`timescale 1ns/1ns

module lsu_tag_fifo
    import lsu_pkg::*;
(
    input  logic clk_i,
    input  logic rst_i,
    input  logic push_i,
    input  tag_t data_i,
    input  logic pop_i,
    output tag_t data_o
);

    tag_t     ram_q [TAG_DEPTH];
    tag_ptr_t rd_ptr_q;
    tag_ptr_t wr_ptr_q;
    tag_cnt_t count_q;

    // Circular increment
    function automatic tag_ptr_t next_ptr(input tag_ptr_t ptr);
        next_ptr = (ptr == tag_ptr_t'(TAG_DEPTH - 1)) ? '0 : ptr + tag_ptr_t'(1);
    endfunction

    always_ff @(posedge clk_i or posedge rst_i)
    begin
        if (rst_i)
        begin
            rd_ptr_q <= '0;
            wr_ptr_q <= '0;
            count_q  <= '0;
        end
        else
        begin
            if (push_i)
                wr_ptr_q <= next_ptr(wr_ptr_q);
            if (pop_i)
                rd_ptr_q <= next_ptr(rd_ptr_q);

            if (push_i && !pop_i)
                count_q <= count_q + tag_cnt_t'(1);
            else if (pop_i && !push_i)
                count_q <= count_q - tag_cnt_t'(1);
        end
    end

    always_ff @(posedge clk_i)
    begin
        if (push_i)
            ram_q[wr_ptr_q] <= data_i;
    end

    // Head entry, valid whenever count is nonzero
    assign data_o = ram_q[rd_ptr_q];

    assert property (@(posedge clk_i) disable iff (rst_i)
        push_i |-> (count_q != tag_cnt_t'(TAG_DEPTH)))
        else $error("lsu_tag_fifo: push while full");

    assert property (@(posedge clk_i) disable iff (rst_i)
        pop_i |-> (count_q != '0))
        else $error("lsu_tag_fifo: pop while empty");

endmodule

/* source/lsu_top.sv */
// LSU top level joining the request stage, tag FIFO and response stage
`timescale 1ns/1ns

module lsu_top
    import lsu_pkg::*;
(
    input  logic    clk_i,
    input  logic    rst_i,

    // Core side
    input  logic    opcode_valid_i,
    input  inst_t   opcode_opcode_i,
    input  word_t   opcode_ra_operand_i,
    input  word_t   opcode_rb_operand_i,
    output logic    stall_o,
    output logic    writeback_valid_o,
    output word_t   writeback_value_o,
    output exc_t    writeback_exception_o,

    // Memory side
    output word_t   mem_addr_o,
    output word_t   mem_data_wr_o,
    output logic    mem_rd_o,
    output strobe_t mem_wr_o,
    input  logic    mem_accept_i,
    input  logic    mem_ack_i,
    input  logic    mem_error_i,
    input  word_t   mem_data_rd_i
);

    logic tag_push;
    tag_t tag_data;
    logic tag_pop;
    tag_t tag_head;
    logic dummy_ack;

    lsu_request u_request (
        .clk_i               (clk_i),
        .rst_i               (rst_i),
        .opcode_valid_i      (opcode_valid_i),
        .opcode_opcode_i     (opcode_opcode_i),
        .opcode_ra_operand_i (opcode_ra_operand_i),
        .opcode_rb_operand_i (opcode_rb_operand_i),
        .mem_accept_i        (mem_accept_i),
        .mem_ack_i           (mem_ack_i),
        .mem_error_i         (mem_error_i),
        .mem_addr_o          (mem_addr_o),
        .mem_data_wr_o       (mem_data_wr_o),
        .mem_rd_o            (mem_rd_o),
        .mem_wr_o            (mem_wr_o),
        .stall_o             (stall_o),
        .tag_push_o          (tag_push),
        .tag_data_o          (tag_data),
        .dummy_ack_o         (dummy_ack)
    );

    lsu_tag_fifo u_tag_fifo (
        .clk_i  (clk_i),
        .rst_i  (rst_i),
        .push_i (tag_push),
        .data_i (tag_data),
        .pop_i  (tag_pop),
        .data_o (tag_head)
    );

    lsu_response u_response (
        .clk_i                 (clk_i),
        .rst_i                 (rst_i),
        .mem_ack_i             (mem_ack_i),
        .mem_error_i           (mem_error_i),
        .mem_data_rd_i         (mem_data_rd_i),
        .dummy_ack_i           (dummy_ack),
        .tag_i                 (tag_head),
        .tag_pop_o             (tag_pop),
        .writeback_valid_o     (writeback_valid_o),
        .writeback_value_o     (writeback_value_o),
        .writeback_exception_o (writeback_exception_o)
    );

endmodule

/* verification/lsu_tb.sv */
// Testbench for the LSU with random loads and stores, a memory responder and a reference model
`timescale 1ns/1ns

module lsu_tb
    import lsu_pkg::*;
();

    localparam int NUM_INST        = 400;
    localparam int CLK_PERIOD      = 10;
    localparam int RESET_CYCLES    = 8;
    localparam int CYCLES_PER_INST = 12;
    localparam int WATCHDOG_CYCLES = NUM_INST * CYCLES_PER_INST + RESET_CYCLES;
    localparam int MEM_WORDS       = 64;

    typedef struct packed {
        logic        is_load;
        logic [2:0]  funct3;
        logic [31:0] addr;
        logic [31:0] data;
    } access_t;

    logic    clk_i               = 1'b0;
    logic    rst_i               = 1'b1;
    logic    opcode_valid_i      = 1'b0;
    inst_t   opcode_opcode_i     = '0;
    word_t   opcode_ra_operand_i = '0;
    word_t   opcode_rb_operand_i = '0;
    logic    mem_accept_i        = 1'b0;
    logic    mem_ack_i           = 1'b0;
    logic    mem_error_i         = 1'b0;
    word_t   mem_data_rd_i       = '0;
    logic    stall_o;
    logic    writeback_valid_o;
    word_t   writeback_value_o;
    exc_t    writeback_exception_o;
    word_t   mem_addr_o;
    word_t   mem_data_wr_o;
    logic    mem_rd_o;
    strobe_t mem_wr_o;

    logic [31:0] lfsr_state = 32'ha1ad_71e8;
    access_t     inst_q[$];
    access_t     req_q[$];
    logic        err_q[$];
    word_t       resp_mem[MEM_WORDS];
    word_t       model_mem[MEM_WORDS];
    int          ack_wait;
    logic        ack_err;
    word_t       ack_data;
    logic        hold_valid;
    word_t       hold_addr;
    word_t       hold_data;
    logic        hold_rd;
    strobe_t     hold_wr;
    int          wb_count       = 0;
    int          mismatch_count = 0;
    int          other_count    = 0;

    lsu_top lsu_top_i (
        .clk_i                 (clk_i),
        .rst_i                 (rst_i),
        .opcode_valid_i        (opcode_valid_i),
        .opcode_opcode_i       (opcode_opcode_i),
        .opcode_ra_operand_i   (opcode_ra_operand_i),
        .opcode_rb_operand_i   (opcode_rb_operand_i),
        .stall_o               (stall_o),
        .writeback_valid_o     (writeback_valid_o),
        .writeback_value_o     (writeback_value_o),
        .writeback_exception_o (writeback_exception_o),
        .mem_addr_o            (mem_addr_o),
        .mem_data_wr_o         (mem_data_wr_o),
        .mem_rd_o              (mem_rd_o),
        .mem_wr_o              (mem_wr_o),
        .mem_accept_i          (mem_accept_i),
        .mem_ack_i             (mem_ack_i),
        .mem_error_i           (mem_error_i),
        .mem_data_rd_i         (mem_data_rd_i)
    );

    initial
    begin
        forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
    end

    //--------------------------------------------------
    // Random source and access rules
    //--------------------------------------------------
    // Fibonacci LFSR, taps 32 22 2 1, one step per bit
    function automatic logic [31:0] rand_bits(input int width);
        logic [31:0] value;
        logic        fb;
        int          i;
        value = '0;
        for (i = 0; i < width; i++)
        begin
            fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            value      = {value[30:0], fb};
        end
        return value;
    endfunction

    function automatic word_t fill_word(input logic [5:0] index);
        logic [7:0] a;
        a = {2'b00, index};
        return {a ^ 8'hc3, ~a, a + 8'h11, a};
    endfunction

    function automatic funct3_t load_funct3(input logic [2:0] sel);
        case (sel)
            3'd0, 3'd5: return F3_B;
            3'd1, 3'd6: return F3_H;
            3'd2, 3'd7: return F3_W;
            3'd3:       return F3_BU;
            default:    return F3_HU;
        endcase
    endfunction

    function automatic funct3_t store_funct3(input logic [1:0] sel);
        case (sel)
            2'd1:    return F3_H;
            2'd2:    return F3_W;
            default: return F3_B;
        endcase
    endfunction

    function automatic string op_name(input access_t acc);
        if (acc.is_load)
        begin
            case (acc.funct3)
                F3_B:    return "LB";
                F3_H:    return "LH";
                F3_W:    return "LW";
                F3_BU:   return "LBU";
                default: return "LHU";
            endcase
        end
        case (acc.funct3)
            F3_H:    return "SH";
            F3_W:    return "SW";
            default: return "SB";
        endcase
    endfunction

    // Halves on even bytes, words on multiples of four
    function automatic logic misaligned(input access_t acc);
        case (acc.funct3[1:0])
            2'd1:    return acc.addr[0];
            2'd2:    return acc.addr[1:0] != 2'b00;
            default: return 1'b0;
        endcase
    endfunction

    // Lanes from the byte offset up through the access size
    function automatic strobe_t expected_strobe(input access_t acc);
        strobe_t s;
        int      first;
        int      last;
        int      k;
        first = int'(acc.addr[1:0]);
        last  = first + (1 << acc.funct3[1:0]) - 1;
        for (k = 0; k < 4; k++)
            s[k] = (k >= first) && (k <= last);
        return s;
    endfunction

    // Store operand repeated across every lane it could occupy
    function automatic word_t expected_lanes(input access_t acc);
        case (acc.funct3[1:0])
            2'd0:    return {4{acc.data[7:0]}};
            2'd1:    return {2{acc.data[15:0]}};
            default: return acc.data;
        endcase
    endfunction

    function automatic word_t lane_mask(input strobe_t s);
        return {{8{s[3]}}, {8{s[2]}}, {8{s[1]}}, {8{s[0]}}};
    endfunction

    function automatic word_t merge_lanes(input word_t old, input strobe_t s, input word_t data);
        return (old & ~lane_mask(s)) | (data & lane_mask(s));
    endfunction

    function automatic word_t load_value(input word_t word, input access_t acc);
        logic [7:0]  b;
        logic [15:0] h;
        case (acc.addr[1:0])
            2'd0:    b = word[7:0];
            2'd1:    b = word[15:8];
            2'd2:    b = word[23:16];
            default: b = word[31:24];
        endcase
        h = acc.addr[1] ? word[31:16] : word[15:0];
        case (acc.funct3)
            F3_B:    return {{24{b[7]}}, b};
            F3_BU:   return {24'h0, b};
            F3_H:    return {{16{h[15]}}, h};
            F3_HU:   return {16'h0, h};
            default: return word;
        endcase
    endfunction

    //--------------------------------------------------
    // Checks and reporting
    //--------------------------------------------------
    task automatic check_value(input string name, input word_t expected, input word_t actual);
        assert (actual === expected)
        else
        begin
            mismatch_count = mismatch_count + 1;
            $display("mismatch %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic note_failure(input string what);
        other_count = other_count + 1;
        $display("error: %s", what);
    endtask

    task automatic print_summary();
        $display("lsu_tb summary: %0d of %0d writebacks, %0d mismatches, %0d other errors",
                 wb_count, NUM_INST, mismatch_count, other_count);
    endtask

    //--------------------------------------------------
    // Instruction generation
    //--------------------------------------------------
    task automatic build_access(output access_t acc, output inst_t inst, output word_t base);
        logic [11:0] imm;
        logic [3:0]  step;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        acc.is_load = 1'(rand_bits(1));
        if (acc.is_load)
            acc.funct3 = load_funct3(3'(rand_bits(3)));
        else
            acc.funct3 = store_funct3(2'(rand_bits(2)));
        base = 32'h100 + rand_bits(6);
        // Three in four bases forced onto natural alignment
        if (2'(rand_bits(2)) != 2'd0)
        begin
            if (acc.funct3[1:0] == 2'd2)
                base[1:0] = 2'b00;
            else if (acc.funct3[1:0] == 2'd1)
                base[0] = 1'b0;
        end
        step     = 4'(rand_bits(4));
        imm      = {{6{step[3]}}, step, 2'b00};
        rs1      = 5'(rand_bits(5));
        rs2      = 5'(rand_bits(5));
        acc.addr = base + {{20{imm[11]}}, imm};
        acc.data = rand_bits(32);
        if (acc.is_load)
            inst = {imm, rs1, acc.funct3, rs2, OPC_LOAD};
        else
            inst = {imm[11:5], rs2, rs1, acc.funct3, imm[4:0], OPC_STORE};
    endtask

    //--------------------------------------------------
    // Memory responder
    //--------------------------------------------------
    task automatic take_request();
        access_t    want;
        logic [5:0] index;
        index = mem_addr_o[7:2];
        assert (req_q.size() != 0)
        else note_failure("memory request issued with no aligned access waiting");
        if (req_q.size() != 0)
        begin
            want = req_q.pop_front();
            check_value({op_name(want), " request read"}, 32'(want.is_load), 32'(mem_rd_o));
            check_value({op_name(want), " request address"}, {want.addr[31:2], 2'b00},
                        mem_addr_o);
            check_value({op_name(want), " request strobe"},
                        want.is_load ? 32'd0 : 32'(expected_strobe(want)), 32'(mem_wr_o));
            if (!want.is_load)
            begin
                check_value({op_name(want), " request lane data"},
                            expected_lanes(want) & lane_mask(expected_strobe(want)),
                            mem_data_wr_o & lane_mask(expected_strobe(want)));
            end
        end
        ack_err  = (4'(rand_bits(4)) == 4'd0);
        ack_data = resp_mem[index];
        ack_wait = 1 + int'(rand_bits(2));
        err_q.push_back(ack_err);
        // Bus error leaves memory untouched
        if (!ack_err && mem_wr_o != '0)
            resp_mem[index] = merge_lanes(resp_mem[index], mem_wr_o, mem_data_wr_o);
    endtask

    always @(posedge clk_i)
    begin
        logic pending;
        int   i;
        if (rst_i)
        begin
            for (i = 0; i < MEM_WORDS; i++)
                resp_mem[i] = fill_word(6'(i));
            ack_wait     = 0;
            hold_valid   = 1'b0;
            mem_ack_i    <= 1'b0;
            mem_error_i  <= 1'b0;
            mem_accept_i <= 1'b0;
        end
        else
        begin
            pending = mem_rd_o || (mem_wr_o != '0);
            if (hold_valid)
            begin
                check_value("held request address", hold_addr, mem_addr_o);
                check_value("held request data", hold_data, mem_data_wr_o);
                check_value("held request read", 32'(hold_rd), 32'(mem_rd_o));
                check_value("held request strobe", 32'(hold_wr), 32'(mem_wr_o));
            end
            hold_valid = pending && !mem_accept_i;
            hold_addr  = mem_addr_o;
            hold_data  = mem_data_wr_o;
            hold_rd    = mem_rd_o;
            hold_wr    = mem_wr_o;

            if (pending && !mem_accept_i)
            begin
                assert (stall_o)
                else note_failure("stall low while a request waits for accept");
            end

            if (pending && mem_accept_i)
            begin
                assert (ack_wait == 0)
                else note_failure("request accepted while an earlier access was unacknowledged");
            end

            mem_ack_i     <= 1'b0;
            mem_error_i   <= 1'b0;
            mem_data_rd_i <= rand_bits(32);
            // Ack lands 1 to 4 cycles after acceptance
            if (pending && mem_accept_i)
                take_request();
            if (ack_wait != 0)
            begin
                ack_wait = ack_wait - 1;
                if (ack_wait == 0)
                begin
                    mem_ack_i     <= 1'b1;
                    mem_error_i   <= ack_err;
                    mem_data_rd_i <= ack_data;
                end
            end
            mem_accept_i <= (2'(rand_bits(2)) != 2'd0);
        end
    end

    //--------------------------------------------------
    // Reference model and writeback checks
    //--------------------------------------------------
    always @(posedge clk_i)
    begin
        access_t    acc;
        logic       bus_err;
        word_t      want_value;
        exc_t       want_exc;
        logic [5:0] index;
        int         i;
        if (rst_i)
        begin
            for (i = 0; i < MEM_WORDS; i++)
                model_mem[i] = fill_word(6'(i));
        end
        else if (writeback_valid_o)
        begin
            wb_count = wb_count + 1;
            assert (inst_q.size() != 0)
            else note_failure("writeback with no captured instruction waiting");
            if (inst_q.size() != 0)
            begin
                acc        = inst_q.pop_front();
                index      = acc.addr[7:2];
                bus_err    = 1'b0;
                want_value = '0;
                want_exc   = '0;
                if (!misaligned(acc))
                begin
                    assert (err_q.size() != 0)
                    else note_failure("writeback before the memory took the access");
                    if (err_q.size() != 0)
                        bus_err = err_q.pop_front();
                end
                if (misaligned(acc))
                begin
                    want_value = acc.addr;
                    want_exc   = acc.is_load ? EXC_MISALIGNED_LOAD : EXC_MISALIGNED_STORE;
                end
                else if (bus_err)
                begin
                    want_value = acc.addr;
                    want_exc   = acc.is_load ? EXC_FAULT_LOAD : EXC_FAULT_STORE;
                end
                else if (acc.is_load)
                    want_value = load_value(model_mem[index], acc);
                else
                    model_mem[index] = merge_lanes(model_mem[index], expected_strobe(acc),
                                                   expected_lanes(acc));
                check_value({op_name(acc), " writeback value"}, want_value, writeback_value_o);
                check_value({op_name(acc), " writeback exception"}, 32'(want_exc),
                            32'(writeback_exception_o));
            end
        end
    end

    //--------------------------------------------------
    // Core driver and end of run
    //--------------------------------------------------
    initial
    begin
        access_t acc;
        inst_t   inst;
        word_t   base;
        int      n;
        repeat (RESET_CYCLES) @(posedge clk_i);
        rst_i <= 1'b0;
        @(posedge clk_i);
        for (n = 0; n < NUM_INST; n++)
        begin
            build_access(acc, inst, base);
            // Occasional bubble
            if (3'(rand_bits(3)) == 3'd0)
            begin
                opcode_valid_i <= 1'b0;
                @(posedge clk_i);
            end
            opcode_valid_i      <= 1'b1;
            opcode_opcode_i     <= inst;
            opcode_ra_operand_i <= base;
            opcode_rb_operand_i <= acc.data;
            @(posedge clk_i);
            while (stall_o)
                @(posedge clk_i);
            inst_q.push_back(acc);
            if (!misaligned(acc))
                req_q.push_back(acc);
        end
        opcode_valid_i <= 1'b0;

        while (wb_count < NUM_INST)
            @(posedge clk_i);
        repeat (10) @(posedge clk_i);
        assert (wb_count == NUM_INST)
        else note_failure("more writebacks than captured instructions");
        assert (inst_q.size() == 0 && req_q.size() == 0 && err_q.size() == 0)
        else note_failure("accesses left unfinished at end of run");

        print_summary();
        if (mismatch_count == 0 && other_count == 0)
            $display("TEST OK");
        else
            $display("TEST FAILED");
        $finish;
    end

    // Watchdog sized from the instruction count
    initial
    begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        note_failure("watchdog expired before all writebacks arrived");
        print_summary();
        $display("TEST FAILED");
        $finish;
    end

endmodule
